// ==== testbench/copy_cases.txt ====
# f <flags hex> <header length hex> <task hex> <last rem bin> <words> <tx stall> <rx stall>
# w <payload word hex>, one line per word of the frame above
f 1 00000010 001 0000 4 0 0
w 01234567
w 89abcdef
w fedcba98
w 76543210
f 4 0000000b 07f 0001 3 0 1
w a1a2a3a4
w b1b2b3b4
w c1c2c3c4
f 2 00000002 3ff 0011 1 1 0
w deadbeef
f 7 00000005 155 0111 2 0 0
w 11223344
w 55667788
f 0 0000000c 200 0000 2 1 1
w 0f0f0f0f
w f0f0f0f0
f 3 00000013 0a4 0001 5 0 1
w 13579bdf
w 2468ace0
w 31415926
w 27182818
w 99aabbcc
f 6 0000000c 31b 0000 3 1 1
w 5a5a5a5a
w a5a5a5a5
w 3c3c3c3c

// ==== vlog.f ====
+incdir+hw
hw/ll_pkg.sv
hw/copy_pkg.sv
hw/sync_fifo.sv
hw/ll_frame_parser.sv
hw/ll_frame_builder.sv
hw/comp_unit_top.sv
testbench/comp_unit_properties.sv
testbench/comp_unit_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat vlog.f))

.PHONY: all run clean

all: run

obj_dir/Vcomp_unit_tb: vlog.f $(SRCS) hw/lldma_params.svh
	verilator --binary --timing --assert -Wno-fatal --top-module comp_unit_tb -f vlog.f

# pass only when the pass line shows up in the output
run: obj_dir/Vcomp_unit_tb
	./obj_dir/Vcomp_unit_tb | tee /dev/stderr | grep -x 'test passed' > /dev/null

clean:
	rm -rf obj_dir

// ==== testbench/comp_unit_tb.sv ====
`include "lldma_params.svh"

module comp_unit_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int PERIOD = 40;

   logic             clk;
   logic             rst_n;
   ll_pkg::ll_word_t tx_word_i;
   logic             tx_src_rdy_n_i;
   logic             tx_dst_rdy_n_o;
   ll_pkg::ll_word_t rx_word_o;
   logic             rx_src_rdy_n_o;
   logic             rx_dst_rdy_n_i;

   // frames as read from the case file
   copy_pkg::desc_t  hdr_q[$];
   ll_pkg::rem_t     rem_q[$];
   int               npay_q[$];
   bit               txs_q[$];
   bit               rxs_q[$];
   logic [31:0]      pay_q[$];

   ll_pkg::ll_word_t exp_words[$];
   logic [31:0]      exp_count[$];
   int               pay_seen;
   int               trl_idx;
   bit               in_trailer;
   int               frames_done;
   int               case_words;

   logic [31:0]      lfsr;
   bit               tx_stall;
   bit               rx_stall;
   bit               rx_stall_en;

   comp_unit_top UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_word_i      (tx_word_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .rx_word_o      (rx_word_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
   );

   always #(PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bit(output bit b);
      lfsr = lfsr_step(lfsr);
      b    = lfsr[0];
   endtask

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1, "stopping at the first error");
   endtask

   function automatic ll_pkg::ll_word_t idle_word();
      ll_pkg::ll_word_t w;
      w       = '0;
      w.sof_n = 1'b1;
      w.eof_n = 1'b1;
      w.sop_n = 1'b1;
      w.eop_n = 1'b1;
      return w;
   endfunction

   function automatic string word_text(input ll_pkg::ll_word_t w);
      return $sformatf("data %h rem %b sof_n %b eof_n %b sop_n %b eop_n %b",
                       w.data, w.rem, w.sof_n, w.eof_n, w.sop_n, w.eop_n);
   endfunction

   // rem 0000/0001/0011/0111 keeps 4/3/2/1 bytes from the top
   function automatic int kept_bytes(input ll_pkg::rem_t rem);
      case (rem)
         4'b0001: return 3;
         4'b0011: return 2;
         4'b0111: return 1;
         default: return 4;
      endcase
   endfunction

   function automatic ll_pkg::ll_word_t expect_payload(input logic [31:0] raw,
         input ll_pkg::rem_t rem, input bit first, input bit last);
      ll_pkg::ll_word_t w;
      w       = idle_word();
      w.data  = raw;
      w.sof_n = !first;
      w.sop_n = !first;
      if (last) begin
         w.data  = raw & (32'hffff_ffff << (8 * (4 - kept_bytes(rem))));
         w.rem   = rem;
         w.eop_n = 1'b0;
      end
      return w;
   endfunction

   // filler in the unused header bits must not leak into the descriptor
   function automatic logic [31:0] header_data(input copy_pkg::desc_t hdr, input int idx);
      logic [31:0] d;
      case (idx)
         `LL_FLAG_WORD: d = {hdr.flags, 29'h0a5_5a5a};
         `LL_LEN_WORD:  d = hdr.length;
         `LL_TASK_WORD: d = {22'h15_a5a3, hdr.task_idx};
         default:       d = {24'h5a_c000, 8'(idx)};
      endcase
      return d;
   endfunction

   task automatic check_ready(input logic exp, input logic got, input string name);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED at %0t ns: %s exp %b, got %b",
                            $time, name, exp, got));
      end
   endtask

   task automatic check_word(input ll_pkg::ll_word_t exp, input ll_pkg::ll_word_t got);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED at %0t ns: frame %0d payload word %0d, exp %s, got %s",
                            $time, frames_done, pay_seen, word_text(exp), word_text(got)));
      end
   endtask

   task automatic check_trailer(input copy_pkg::desc_t hdr, input logic [31:0] count,
                                input int idx, input ll_pkg::ll_word_t got);
      ll_pkg::ll_word_t exp;
      exp = idle_word();
      case (idx)
         `LL_FLAG_WORD: begin
            exp.data[`LL_DATA_W-1 -: 3] = hdr.flags;
            exp.data[`STATUS_BIT]       = (count == hdr.length);
         end
         `LL_LEN_WORD:  exp.data = count;
         `LL_TASK_WORD: exp.data[`TASK_W-1:0] = hdr.task_idx;
         default: ;
      endcase
      exp.eof_n = (idx != `LL_HDR_WORDS - 1);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED at %0t ns: frame %0d trailer word %0d, exp %s, got %s",
                            $time, frames_done, idx, word_text(exp), word_text(got)));
      end
   endtask

   task automatic read_cases();
      int              fd;
      int              n;
      string           line;
      logic [2:0]      flags;
      logic [31:0]     len;
      logic [9:0]      tsk;
      logic [3:0]      rem;
      int              words;
      int              txs;
      int              rxs;
      logic [31:0]     data;
      copy_pkg::desc_t hdr;
      fd = $fopen("testbench/copy_cases.txt", "r");
      if (fd == 0) begin
         stop_run("could not open the case file testbench/copy_cases.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.getc(0) == "f") begin
               n = $sscanf(line, "f %h %h %h %b %d %d %d", flags, len, tsk, rem, words, txs, rxs);
               if (n != 7 || words < 1) begin
                  stop_run($sformatf("malformed frame line in case file: %s", line));
               end else begin
                  hdr.flags    = flags;
                  hdr.length   = len;
                  hdr.task_idx = tsk;
                  hdr_q.push_back(hdr);
                  rem_q.push_back(rem);
                  npay_q.push_back(words);
                  txs_q.push_back(txs != 0);
                  rxs_q.push_back(rxs != 0);
               end
            end else if (line.getc(0) == "w") begin
               n = $sscanf(line, "w %h", data);
               pay_q.push_back(data);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic build_expected();
      int base;
      int bytes;
      bit last;
      base = 0;
      foreach (hdr_q[f]) begin
         bytes = 0;
         for (int j = 0; j < npay_q[f]; j++) begin
            last = (j == npay_q[f] - 1);
            exp_words.push_back(expect_payload(pay_q[base + j], rem_q[f], j == 0, last));
            bytes += last ? kept_bytes(rem_q[f]) : 4;
         end
         exp_count.push_back(32'(bytes));
         base += npay_q[f];
      end
      if (base != pay_q.size() || hdr_q.size() == 0) begin
         stop_run("case file payload words do not match its frame lines");
      end
   endtask

   task automatic send_word(input ll_pkg::ll_word_t w, input bit may_stall);
      bit taken;
      taken = 1'b0;
      while (!taken) begin
         if (may_stall && tx_stall) begin
            tx_src_rdy_n_i = 1'b1;
         end else begin
            tx_word_i      = w;
            tx_src_rdy_n_i = 1'b0;
         end
         @(negedge clk);
         taken = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
         @(posedge clk);
         #2;
      end
   endtask

   task automatic send_frame(input int f, input int base);
      ll_pkg::ll_word_t w;
      bit               last;
      for (int i = 0; i < `LL_HDR_WORDS; i++) begin
         w       = idle_word();
         w.data  = header_data(hdr_q[f], i);
         w.sof_n = (i != 0);
         send_word(w, txs_q[f]);
      end
      for (int j = 0; j < npay_q[f]; j++) begin
         last    = (j == npay_q[f] - 1);
         w       = idle_word();
         w.data  = pay_q[base + j];
         w.rem   = last ? rem_q[f] : 4'b0000;
         w.sop_n = (j != 0);
         w.eop_n = !last;
         w.eof_n = !last;
         send_word(w, txs_q[f]);
      end
   endtask

   task automatic take_word(input ll_pkg::ll_word_t got);
      if (frames_done >= hdr_q.size()) begin
         stop_run($sformatf("output word %h appeared after the last frame at %0t ns",
                            got.data, $time));
      end else if (!in_trailer) begin
         check_word(exp_words.pop_front(), got);
         pay_seen++;
         if (pay_seen == npay_q[frames_done]) begin
            in_trailer = 1'b1;
            trl_idx    = 0;
         end
      end else begin
         check_trailer(hdr_q[frames_done], exp_count[frames_done], trl_idx, got);
         trl_idx++;
         if (trl_idx == `LL_HDR_WORDS) begin
            in_trailer = 1'b0;
            pay_seen   = 0;
            frames_done++;
            if (frames_done < hdr_q.size()) begin
               rx_stall_en = rxs_q[frames_done];
            end
         end
      end
   endtask

   // stall bits drawn every cycle so the sequence does not depend on traffic
   always @(posedge clk) begin
      bit b0;
      bit b1;
      bit b2;
      #1;
      draw_bit(b0);
      draw_bit(b1);
      draw_bit(b2);
      tx_stall = b0;
      rx_stall = b1 | b2;
   end

   always @(posedge clk) begin
      #2;
      rx_dst_rdy_n_i = rx_stall_en && rx_stall;
   end

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (rst_n === 1'b1 && !rx_src_rdy_n_o && !rx_dst_rdy_n_i) begin
         take_word(rx_word_o);
      end
   end

   initial begin
      wait (case_words > 0);
      #((case_words * 40 + 10) * PERIOD);
      stop_run($sformatf("timeout at %0t ns, %0d frames complete", $time, frames_done));
   end

   initial begin
      int base;
      clk            = 1'b0;
      rst_n          = 1'b0;
      tx_word_i      = idle_word();
      tx_src_rdy_n_i = 1'b1;
      rx_dst_rdy_n_i = 1'b1;
      lfsr           = 32'hf0dc_1582;
      tx_stall       = 1'b0;
      rx_stall       = 1'b0;
      pay_seen       = 0;
      trl_idx        = 0;
      in_trailer     = 1'b0;
      frames_done    = 0;
      case_words     = 0;
      read_cases();
      build_expected();
      rx_stall_en = rxs_q[0];
      foreach (npay_q[f]) begin
         case_words += `LL_HDR_WORDS + npay_q[f];
      end
      repeat (10) @(posedge clk);
      #2;
      // both ports inactive while in reset
      check_ready(1'b1, tx_dst_rdy_n_o, "tx_dst_rdy_n_o in reset");
      check_ready(1'b1, rx_src_rdy_n_o, "rx_src_rdy_n_o in reset");
      rst_n = 1'b1;
      @(posedge clk);
      #2;
      base = 0;
      foreach (hdr_q[f]) begin
         send_frame(f, base);
         base += npay_q[f];
      end
      tx_src_rdy_n_i = 1'b1;
      tx_word_i      = idle_word();
      wait (frames_done == hdr_q.size());
      // a duplicated word would show up here
      repeat (20) @(posedge clk);
      if (UUT.u_builder.u_props.fail_cnt == 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("output port assertions failed");
         $display("test failed");
         $fatal(1, "run ended with errors");
      end
   end

endmodule

// ==== testbench/comp_unit_properties.sv ====
module comp_unit_properties (
   input logic             clk,
   input logic             rst_n,
   input ll_pkg::ll_word_t rx_word_i,
   input logic             rx_src_rdy_n_i,
   input logic             rx_dst_rdy_n_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;

   // a word offered and not taken stays on the port unchanged
   hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n_i && rx_dst_rdy_n_i) |=> (!rx_src_rdy_n_i && $stable(rx_word_i)))
      else begin
         fail_cnt++;
         $error("held output word changed or was withdrawn");
      end

   frame_flags_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_word_i.sof_n || !rx_word_i.eof_n) |-> !rx_src_rdy_n_i)
      else begin
         fail_cnt++;
         $error("sof_n or eof_n low without rx_src_rdy_n low");
      end

   idle_after_reset: assert property (@(posedge clk) !rst_n |=> rx_src_rdy_n_i)
      else begin
         fail_cnt++;
         $error("rx_src_rdy_n low right after reset");
      end

endmodule

bind ll_frame_builder comp_unit_properties u_props (
   .clk            (clk),
   .rst_n          (rst_n),
   .rx_word_i      (rx_word_o),
   .rx_src_rdy_n_i (rx_src_rdy_n_o),
   .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
);

// ==== hw/comp_unit_top.sv ====
`include "lldma_params.svh"

module comp_unit_top (
   input  logic              clk,
   input  logic              rst_n,
   input  ll_pkg::ll_word_t  tx_word_i,
   input  logic              tx_src_rdy_n_i,
   output logic              tx_dst_rdy_n_o,
   output ll_pkg::ll_word_t  rx_word_o,
   output logic              rx_src_rdy_n_o,
   input  logic              rx_dst_rdy_n_i
);

   copy_pkg::desc_t desc_in;
   copy_pkg::desc_t desc_out;
   copy_pkg::beat_t beat_in;
   copy_pkg::beat_t beat_out;
   logic            desc_push;
   logic            desc_full;
   logic            desc_pop;
   logic            desc_empty;
   logic            beat_push;
   logic            beat_full;
   logic            beat_pop;
   logic            beat_empty;

   ll_frame_parser u_parser (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_word_i      (tx_word_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .desc_push_o    (desc_push),
      .desc_o         (desc_in),
      .desc_full_i    (desc_full),
      .beat_push_o    (beat_push),
      .beat_o         (beat_in),
      .beat_full_i    (beat_full)
   );

   // descriptors, two deep so a second frame can enter
   sync_fifo #(
      .item_t (copy_pkg::desc_t),
      .depth  (`DESC_FIFO_DEPTH)
   ) u_desc_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (desc_push),
      .item_i  (desc_in),
      .full_o  (desc_full),
      .pop_i   (desc_pop),
      .item_o  (desc_out),
      .empty_o (desc_empty)
   );

   sync_fifo #(
      .item_t (copy_pkg::beat_t),
      .depth  (`BEAT_FIFO_DEPTH)
   ) u_beat_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (beat_push),
      .item_i  (beat_in),
      .full_o  (beat_full),
      .pop_i   (beat_pop),
      .item_o  (beat_out),
      .empty_o (beat_empty)
   );

   ll_frame_builder u_builder (
      .clk            (clk),
      .rst_n          (rst_n),
      .desc_i         (desc_out),
      .desc_empty_i   (desc_empty),
      .desc_pop_o     (desc_pop),
      .beat_i         (beat_out),
      .beat_empty_i   (beat_empty),
      .beat_pop_o     (beat_pop),
      .rx_word_o      (rx_word_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
   );

endmodule

// ==== hw/ll_frame_builder.sv ====
`include "lldma_params.svh"

module ll_frame_builder (
   input  logic              clk,
   input  logic              rst_n,
   input  copy_pkg::desc_t   desc_i,
   input  logic              desc_empty_i,
   output logic              desc_pop_o,
   input  copy_pkg::beat_t   beat_i,
   input  logic              beat_empty_i,
   output logic              beat_pop_o,
   output ll_pkg::ll_word_t  rx_word_o,
   output logic              rx_src_rdy_n_o,
   input  logic              rx_dst_rdy_n_i
);

   localparam int IDX_W = $clog2(`LL_HDR_WORDS);
   localparam int BYTES = `LL_DATA_W / 8;

   typedef enum logic [1:0] {
      B_IDLE,
      B_PAY_HI,
      B_PAY_LO,
      B_TRL
   } state_t;

   state_t                state_q;
   logic [IDX_W-1:0]      trl_idx_q;
   logic [`LL_DATA_W-1:0] byte_cnt_q;
   logic                  first_q;
   logic                  xfer;
   logic                  is_eop;
   logic [2:0]            word_bytes;
   copy_pkg::trl_flag_t   trl_flag;

   always_comb begin
      case (state_q)
         B_PAY_HI: is_eop = beat_i.last && !beat_i.two;
         B_PAY_LO: is_eop = beat_i.last;
         default:  is_eop = 1'b0;
      endcase
   end

   assign word_bytes = is_eop ? ll_pkg::rem_valid_bytes(beat_i.rem) : 3'(BYTES);

   always_comb begin
      case (state_q)
         B_PAY_HI, B_PAY_LO: rx_src_rdy_n_o = beat_empty_i;
         B_TRL:              rx_src_rdy_n_o = desc_empty_i;
         default:            rx_src_rdy_n_o = 1'b1;
      endcase
   end

   assign xfer       = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;
   assign beat_pop_o = xfer && (state_q == B_PAY_LO || (state_q == B_PAY_HI && !beat_i.two));
   assign desc_pop_o = xfer && state_q == B_TRL && trl_idx_q == IDX_W'(`LL_HDR_WORDS - 1);

   assign trl_flag.flags  = desc_i.flags;
   assign trl_flag.status = (byte_cnt_q == desc_i.length);
   assign trl_flag.rsvd   = '0;

   always_comb begin
      rx_word_o       = '0;
      rx_word_o.sof_n = 1'b1;
      rx_word_o.eof_n = 1'b1;
      rx_word_o.sop_n = 1'b1;
      rx_word_o.eop_n = 1'b1;
      case (state_q)
         B_PAY_HI: begin
            rx_word_o.data  = beat_i.data[2*`LL_DATA_W-1 -: `LL_DATA_W];
            rx_word_o.sof_n = !first_q;
            rx_word_o.sop_n = !first_q;
         end
         B_PAY_LO: rx_word_o.data = beat_i.data[`LL_DATA_W-1:0];
         B_TRL: begin
            if (trl_idx_q == IDX_W'(`LL_FLAG_WORD)) begin
               rx_word_o.data = trl_flag;
            end
            if (trl_idx_q == IDX_W'(`LL_LEN_WORD)) begin
               rx_word_o.data = byte_cnt_q;
            end
            if (trl_idx_q == IDX_W'(`LL_TASK_WORD)) begin
               rx_word_o.data = {{(`LL_DATA_W - `TASK_W){1'b0}}, desc_i.task_idx};
            end
            rx_word_o.eof_n = (trl_idx_q != IDX_W'(`LL_HDR_WORDS - 1));
         end
         default: rx_word_o.data = '0;
      endcase
      // final payload word carries the input rem
      if (is_eop) begin
         rx_word_o.eop_n = 1'b0;
         rx_word_o.rem   = beat_i.rem;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= B_IDLE;
         trl_idx_q  <= '0;
         byte_cnt_q <= '0;
         first_q    <= 1'b0;
      end else begin
         case (state_q)
            B_IDLE: begin
               if (!desc_empty_i && !beat_empty_i) begin
                  state_q    <= B_PAY_HI;
                  first_q    <= 1'b1;
                  byte_cnt_q <= '0;
               end
            end
            B_PAY_HI: begin
               if (xfer) begin
                  first_q    <= 1'b0;
                  byte_cnt_q <= byte_cnt_q + `LL_DATA_W'(word_bytes);
                  trl_idx_q  <= '0;
                  state_q    <= beat_i.two ? B_PAY_LO : B_TRL;
               end
            end
            B_PAY_LO: begin
               if (xfer) begin
                  byte_cnt_q <= byte_cnt_q + `LL_DATA_W'(word_bytes);
                  trl_idx_q  <= '0;
                  state_q    <= beat_i.last ? B_TRL : B_PAY_HI;
               end
            end
            B_TRL: begin
               if (xfer) begin
                  trl_idx_q <= trl_idx_q + 1'b1;
                  if (trl_idx_q == IDX_W'(`LL_HDR_WORDS - 1)) begin
                     state_q <= B_IDLE;
                  end
               end
            end
            default: state_q <= B_IDLE;
         endcase
      end
   end

endmodule

// ==== hw/ll_frame_parser.sv ====
`include "lldma_params.svh"

module ll_frame_parser (
   input  logic              clk,
   input  logic              rst_n,
   input  ll_pkg::ll_word_t  tx_word_i,
   input  logic              tx_src_rdy_n_i,
   output logic              tx_dst_rdy_n_o,
   output logic              desc_push_o,
   output copy_pkg::desc_t   desc_o,
   input  logic              desc_full_i,
   output logic              beat_push_o,
   output copy_pkg::beat_t   beat_o,
   input  logic              beat_full_i
);

   localparam int IDX_W  = $clog2(`LL_HDR_WORDS);
   localparam int BYTES  = `LL_DATA_W / 8;
   localparam int FLAG_W = $bits(copy_pkg::op_flags_t);

   typedef enum logic [2:0] {
      S_INIT,
      S_IDLE,
      S_HDR,
      S_PAY0,
      S_PAY1
   } state_t;

   state_t                state_q;
   logic [IDX_W-1:0]      hdr_idx_q;
   logic [`LL_DATA_W-1:0] first_q;
   logic [`LL_DATA_W-1:0] masked;
   logic [2:0]            keep_bytes;
   logic                  rdy;
   logic                  accept;

   // port opens one cycle after reset
   always_comb begin
      case (state_q)
         S_IDLE:  rdy = !desc_full_i;
         S_HDR:   rdy = 1'b1;
         // a pending push may take the last free slot
         S_PAY0:  rdy = !beat_full_i && !beat_push_o;
         S_PAY1:  rdy = !beat_full_i;
         default: rdy = 1'b0;
      endcase
   end

   assign tx_dst_rdy_n_o = !rdy;
   assign accept         = !tx_src_rdy_n_i && rdy;

   // clear the bytes past rem on the final word
   always_comb begin
      keep_bytes = ll_pkg::rem_valid_bytes(tx_word_i.rem);
      masked     = tx_word_i.data;
      if (!tx_word_i.eop_n) begin
         for (int b = 0; b < BYTES; b++) begin
            if (b >= int'(keep_bytes)) begin
               masked[`LL_DATA_W-1-8*b -: 8] = 8'h00;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q     <= S_INIT;
         hdr_idx_q   <= '0;
         desc_push_o <= 1'b0;
         beat_push_o <= 1'b0;
      end else begin
         desc_push_o <= 1'b0;
         beat_push_o <= 1'b0;
         case (state_q)
            S_INIT: state_q <= S_IDLE;
            S_IDLE: begin
               if (accept && !tx_word_i.sof_n) begin
                  state_q   <= S_HDR;
                  hdr_idx_q <= IDX_W'(1);
               end
            end
            S_HDR: begin
               if (accept) begin
                  hdr_idx_q <= hdr_idx_q + 1'b1;
                  if (hdr_idx_q == IDX_W'(`LL_TASK_WORD)) begin
                     desc_push_o <= 1'b1;
                  end
                  if (hdr_idx_q == IDX_W'(`LL_HDR_WORDS - 1)) begin
                     state_q <= S_PAY0;
                  end
               end
            end
            S_PAY0: begin
               if (accept) begin
                  beat_push_o <= !tx_word_i.eop_n;
                  state_q     <= tx_word_i.eop_n ? S_PAY1 : S_IDLE;
               end
            end
            S_PAY1: begin
               if (accept) begin
                  beat_push_o <= 1'b1;
                  state_q     <= tx_word_i.eop_n ? S_PAY0 : S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept && state_q == S_HDR) begin
         if (hdr_idx_q == IDX_W'(`LL_FLAG_WORD)) begin
            desc_o.flags <= tx_word_i.data[`LL_DATA_W-1 -: FLAG_W];
         end
         if (hdr_idx_q == IDX_W'(`LL_LEN_WORD)) begin
            desc_o.length <= tx_word_i.data;
         end
         if (hdr_idx_q == IDX_W'(`LL_TASK_WORD)) begin
            desc_o.task_idx <= tx_word_i.data[`TASK_W-1:0];
         end
      end
      if (accept && state_q == S_PAY0) begin
         first_q <= tx_word_i.data;
         // odd word count, lone word goes out in the high half
         beat_o.data <= {masked, {`LL_DATA_W{1'b0}}};
         beat_o.two  <= 1'b0;
         beat_o.last <= 1'b1;
         beat_o.rem  <= tx_word_i.rem;
      end
      if (accept && state_q == S_PAY1) begin
         beat_o.data <= {first_q, masked};
         beat_o.two  <= 1'b1;
         beat_o.last <= !tx_word_i.eop_n;
         beat_o.rem  <= tx_word_i.eop_n ? 4'b0000 : tx_word_i.rem;
      end
   end

endmodule

// ==== hw/sync_fifo.sv ====
module sync_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  depth  = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push_i,
   input  item_t item_i,
   output logic  full_o,
   input  logic  pop_i,
   output item_t item_o,
   output logic  empty_o
);

   localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
   localparam int CNT_W = $clog2(depth + 1);

   item_t            mem [depth];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign full_o  = (count_q == CNT_W'(depth));
   assign empty_o = (count_q == '0);

   // show-ahead read
   assign item_o = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= item_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// ==== hw/copy_pkg.sv ====
`include "lldma_params.svh"

package copy_pkg;

   // copy, compress, decompress request bits, passed through untouched
   typedef logic [2:0] op_flags_t;

   typedef struct packed {
      op_flags_t             flags;
      logic [`LL_DATA_W-1:0] length;
      logic [`TASK_W-1:0]    task_idx;
   } desc_t;

   // two payload words, first word in the high half
   typedef struct packed {
      logic [2*`LL_DATA_W-1:0] data;
      logic                    two;
      logic                    last;
      ll_pkg::rem_t            rem;
   } beat_t;

   // trailer flag word, status sits right below the op bits
   typedef struct packed {
      op_flags_t              flags;
      logic                   status;
      logic [`STATUS_BIT-1:0] rsvd;
   } trl_flag_t;

endpackage

// ==== hw/ll_pkg.sv ====
`include "lldma_params.svh"

package ll_pkg;

   typedef logic [3:0] rem_t;

   // one word on the port, framing flags active low
   typedef struct packed {
      logic [`LL_DATA_W-1:0] data;
      rem_t                  rem;
      logic                  sof_n;
      logic                  eof_n;
      logic                  sop_n;
      logic                  eop_n;
   } ll_word_t;

   // bytes kept from the top of the final word
   function automatic logic [2:0] rem_valid_bytes(rem_t rem);
      logic [2:0] n;
      case (rem)
         4'b0001: n = 3'd3;
         4'b0011: n = 3'd2;
         4'b0111: n = 3'd1;
         default: n = 3'd4;
      endcase
      return n;
   endfunction

endpackage

// ==== hw/lldma_params.svh ====
`ifndef LLDMA_PARAMS_SVH
`define LLDMA_PARAMS_SVH

// local-link word
`define LL_DATA_W        32

// descriptor header and completion trailer share one layout
`define LL_HDR_WORDS     8
`define LL_FLAG_WORD     4
`define LL_LEN_WORD      5
`define LL_TASK_WORD     6
`define TASK_W           10
`define STATUS_BIT       28

// buffer depths
`define BEAT_FIFO_DEPTH  8
`define DESC_FIFO_DEPTH  2

`endif
